// File: flist.f
sprite_pkg.sv
sprite_table.sv
sprite_hit.sv
layer_compositor.sv
sprite_rom.sv
pixel_output.sv
sprite_renderer.sv
sprite_renderer_checker.sv
tb_sprite_renderer.sv

// File: layer_compositor.sv
// layer compositor
// picks the top-most hit and forms the sprite ROM word address
module layer_compositor #(
	parameter int NUM_SPRITES = 4
) (
	input  logic                  Clk50,
	input  logic                  rst_n,
	input  logic                  in_valid,
	input  logic                  in_blank,
	input  sprite_pkg::hit_t      hits [NUM_SPRITES],
	output logic                  out_valid,
	output logic                  out_blank,
	output logic                  out_hit,
	output sprite_pkg::offset_t   col,
	output sprite_pkg::rom_addr_t rom_addr
);
	import sprite_pkg::*;

	logic       pick_hit;
	sprite_id_t pick_id;
	offset_t    pick_row;
	offset_t    pick_col;

	// --------------------------------------------------
	// priority pick
	// --------------------------------------------------
	// later ids overwrite earlier ones, so the highest
	// numbered hit wins and draws on top
	always_comb
	begin
		pick_hit = 1'b0;
		pick_id  = '0;
		pick_row = '0;
		pick_col = '0;
		for (int i = 0; i < NUM_SPRITES; i++)
		begin
			if (hits[i].hit)
			begin
				pick_hit = 1'b1;
				pick_id  = sprite_id_t'(i);
				pick_row = hits[i].row;
				pick_col = hits[i].col;
			end
		end
	end

	always_ff @(posedge Clk50)
	begin
		if (!rst_n)
			out_valid <= 1'b0;
		else
			out_valid <= in_valid;
	end

	// word address is sprite id then row; don't care without a hit
	always_ff @(posedge Clk50)
	begin
		out_blank <= in_blank;
		out_hit   <= pick_hit;
		col       <= pick_col;
		rom_addr  <= {pick_id, pick_row};
	end

endmodule

// File: pixel_output.sv
// pixel output stage
// nibble pick, background fallback, palette lookup and blanking
module pixel_output (
	input  logic                  Clk50,
	input  logic                  rst_n,
	input  logic                  in_valid,
	input  logic                  in_blank,
	input  logic                  in_hit,
	input  sprite_pkg::offset_t   col,
	input  sprite_pkg::rom_word_t word,
	output logic                  rgb_valid,
	output sprite_pkg::rgb_t      rgb
);
	import sprite_pkg::*;

	color_idx_t nibble;
	color_idx_t color_idx;
	logic [4:0] nib_lsb;

	// --------------------------------------------------
	// nibble select
	// --------------------------------------------------
	// column 0 sits in bits 31..28, so the low bit of the
	// nibble is 4*(7-col), and 7-col is ~col in 3 bits
	assign nib_lsb = {~col, 2'b00};
	assign nibble  = word[nib_lsb +: 4];

	// transparent pixel or no sprite shows the background
	always_comb
	begin
		if (!in_hit || nibble == 4'h0)
			color_idx = BG_INDEX;
		else
			color_idx = nibble;
	end

	always_ff @(posedge Clk50)
	begin
		if (!rst_n)
			rgb_valid <= 1'b0;
		else
			rgb_valid <= in_valid;
	end

	// black during blanking
	always_ff @(posedge Clk50)
	begin
		if (in_blank)
			rgb <= RGB_BLACK;
		else
			rgb <= palette_rgb(color_idx);
	end

endmodule

// File: run_sim.sh
#!/bin/sh
# build and run the sprite renderer testbench with Verilator
rm -rf obj_dir sim.log build.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_sprite_renderer \
	-f flist.f -o sim_tb > build.log 2>&1 \
	|| { cat build.log; echo "build failed"; exit 1; }
./obj_dir/sim_tb > sim.log 2>&1 || echo "simulator exited with an error" >> sim.log
cat sim.log
grep -q "TESTBENCH FAILED" sim.log && { echo "simulation failed"; exit 1; }
grep -q "TESTBENCH PASSED" sim.log || { echo "simulation did not complete"; exit 1; }
exit 0

// File: sprite_hit.sv
// sprite hit unit
// registered 8x8 box test and row/col offset for one sprite
module sprite_hit (
	input  logic                    Clk50,
	input  logic                    rst_n,
	input  logic                    in_valid,
	input  sprite_pkg::pixel_req_t  req,
	input  sprite_pkg::sprite_pos_t pos,
	output logic                    out_valid,
	output logic                    out_blank,
	output sprite_pkg::hit_t        hit
);
	import sprite_pkg::*;

	// 11 bit box edges with no wrap at the screen edge
	logic [10:0] x_end;
	logic [10:0] y_end;
	logic        in_x;
	logic        in_y;
	coord_t      dx;
	coord_t      dy;

	assign x_end = {1'b0, pos.x} + 11'(SPRITE_SIZE);
	assign y_end = {1'b0, pos.y} + 11'(SPRITE_SIZE);

	// corner inclusive and far edge exclusive
	assign in_x = ({1'b0, req.x} >= {1'b0, pos.x}) && ({1'b0, req.x} < x_end);
	assign in_y = ({1'b0, req.y} >= {1'b0, pos.y}) && ({1'b0, req.y} < y_end);

	// offset from the corner
	// low bits only matter inside the box
	assign dx = req.x - pos.x;
	assign dy = req.y - pos.y;

	always_ff @(posedge Clk50)
	begin
		if (!rst_n)
			out_valid <= 1'b0;
		else
			out_valid <= in_valid;
	end

	// payload that travels with out_valid
	always_ff @(posedge Clk50)
	begin
		out_blank <= req.blank;
		hit.hit   <= pos.en && in_x && in_y;
		hit.row   <= dy[2:0];
		hit.col   <= dx[2:0];
	end

endmodule

// File: sprite_pkg.sv
// sprite renderer shared definitions
// widths, pixel and table structs, fixed palette
package sprite_pkg;

	// --------------------------------------------------
	// widths with a meaning
	// --------------------------------------------------
	typedef logic [9:0]  coord_t;
	typedef logic [1:0]  sprite_id_t;
	typedef logic [3:0]  color_idx_t;
	typedef logic [31:0] rom_word_t;
	typedef logic [4:0]  rom_addr_t;
	// row or column inside one 8x8 sprite
	typedef logic [2:0]  offset_t;

	localparam int MAX_SPRITES = 4;
	localparam int SPRITE_SIZE = 8;
	// one word per sprite row
	localparam int ROM_WORDS = MAX_SPRITES * SPRITE_SIZE;
	localparam color_idx_t BG_INDEX = 4'd4;

	// --------------------------------------------------
	// bundled signals
	// --------------------------------------------------
	typedef struct packed {
		logic [7:0] red;
		logic [7:0] green;
		logic [7:0] blue;
	} rgb_t;

	localparam rgb_t RGB_BLACK = '0;

	// one pixel request from the scan source
	typedef struct packed {
		coord_t x;
		coord_t y;
		logic   blank;
	} pixel_req_t;

	// top left corner plus enable
	typedef struct packed {
		coord_t x;
		coord_t y;
		logic   en;
	} sprite_pos_t;

	typedef struct packed {
		sprite_id_t  id;
		sprite_pos_t pos;
	} sprite_wr_t;

	typedef struct packed {
		logic    hit;
		offset_t row;
		offset_t col;
	} hit_t;

	// fixed 16 entry palette, index 0 never shown
	function automatic rgb_t palette_rgb(color_idx_t idx);
		case (idx)
			4'h0: return rgb_t'(24'h000000);
			4'h1: return rgb_t'(24'hFFFFFF);
			4'h2: return rgb_t'(24'hFF0000);
			4'h3: return rgb_t'(24'h00FF00);
			// background grey
			4'h4: return rgb_t'(24'hA0A0A0);
			4'h5: return rgb_t'(24'h0000FF);
			4'h6: return rgb_t'(24'hFFFF00);
			4'h7: return rgb_t'(24'h00FFFF);
			4'h8: return rgb_t'(24'hFF00FF);
			4'h9: return rgb_t'(24'h804000);
			4'hA: return rgb_t'(24'hFF8000);
			4'hB: return rgb_t'(24'h808080);
			4'hC: return rgb_t'(24'h400080);
			4'hD: return rgb_t'(24'h008040);
			4'hE: return rgb_t'(24'hFFC0C0);
			default: return rgb_t'(24'h202020);
		endcase
	endfunction

endpackage

// File: sprite_renderer.sv
// sprite renderer top level
// table, parallel hit units, compositor, ROM and output stage, 4 cycle latency
module sprite_renderer #(
	parameter int NUM_SPRITES = 4
) (
	input  logic                   Clk50,
	input  logic                   rst_n,
	input  logic                   pix_valid,
	input  sprite_pkg::pixel_req_t pix,
	input  logic                   tbl_wr_valid,
	input  sprite_pkg::sprite_wr_t tbl_wr,
	output logic                   rgb_valid,
	output sprite_pkg::rgb_t       rgb
);
	import sprite_pkg::*;

	sprite_pos_t pos [NUM_SPRITES];
	// hit stage, valid and blank used from unit 0 only
	hit_t        hits [NUM_SPRITES];
	logic        hit_valid [NUM_SPRITES];
	logic        hit_blank [NUM_SPRITES];
	// compositor stage
	logic        comp_valid;
	logic        comp_blank;
	logic        comp_hit;
	offset_t     comp_col;
	rom_addr_t   comp_addr;
	// ROM stage
	rom_word_t   rom_data;
	logic        rom_valid;
	logic        rom_blank;
	logic        rom_hit;
	offset_t     rom_col;

	sprite_table #(.NUM_SPRITES(NUM_SPRITES)) sprite_table_inst (
		.Clk50    (Clk50),
		.rst_n    (rst_n),
		.wr_valid (tbl_wr_valid),
		.wr       (tbl_wr),
		.pos      (pos)
	);

	// one identical hit unit per sprite
	for (genvar i = 0; i < NUM_SPRITES; i++)
	begin : g_hit
		sprite_hit sprite_hit_inst (
			.Clk50     (Clk50),
			.rst_n     (rst_n),
			.in_valid  (pix_valid),
			.req       (pix),
			.pos       (pos[i]),
			.out_valid (hit_valid[i]),
			.out_blank (hit_blank[i]),
			.hit       (hits[i])
		);
	end

	layer_compositor #(.NUM_SPRITES(NUM_SPRITES)) layer_compositor_inst (
		.Clk50     (Clk50),
		.rst_n     (rst_n),
		.in_valid  (hit_valid[0]),
		.in_blank  (hit_blank[0]),
		.hits      (hits),
		.out_valid (comp_valid),
		.out_blank (comp_blank),
		.out_hit   (comp_hit),
		.col       (comp_col),
		.rom_addr  (comp_addr)
	);

	sprite_rom sprite_rom_inst (
		.Clk50 (Clk50),
		.addr  (comp_addr),
		.data  (rom_data)
	);

	// --------------------------------------------------
	// ROM stage, side signals follow the ROM read
	// --------------------------------------------------
	always_ff @(posedge Clk50)
	begin
		if (!rst_n)
			rom_valid <= 1'b0;
		else
			rom_valid <= comp_valid;
	end

	always_ff @(posedge Clk50)
	begin
		rom_blank <= comp_blank;
		rom_hit   <= comp_hit;
		rom_col   <= comp_col;
	end

	pixel_output pixel_output_inst (
		.Clk50     (Clk50),
		.rst_n     (rst_n),
		.in_valid  (rom_valid),
		.in_blank  (rom_blank),
		.in_hit    (rom_hit),
		.col       (rom_col),
		.word      (rom_data),
		.rgb_valid (rgb_valid),
		.rgb       (rgb)
	);

endmodule

// File: sprite_renderer_checker.sv
// sprite renderer checker
// reset, latency and blanking properties on the top level ports
module sprite_renderer_checker (
	input logic                   Clk50,
	input logic                   rst_n,
	input logic                   pix_valid,
	input sprite_pkg::pixel_req_t pix,
	input logic                   rgb_valid,
	input sprite_pkg::rgb_t       rgb
);
	timeunit 1ns;
	timeprecision 100ps;
	import sprite_pkg::*;

	// output valid cleared by every reset edge
	assert property (@(posedge Clk50) !rst_n |=> !rgb_valid)
		else $error("rgb_valid high during reset");

	// four register stages from request to colour
	assert property (@(posedge Clk50) disable iff (!rst_n)
		rgb_valid == $past(pix_valid, 4))
		else $error("rgb_valid does not follow pix_valid by four cycles");

	// blanked request comes out black
	assert property (@(posedge Clk50) disable iff (!rst_n)
		(rgb_valid && $past(pix.blank, 4)) |-> (rgb == RGB_BLACK))
		else $error("rgb not black for a blanked request");

endmodule

bind sprite_renderer sprite_renderer_checker checker_inst (
	.Clk50     (Clk50),
	.rst_n     (rst_n),
	.pix_valid (pix_valid),
	.pix       (pix),
	.rgb_valid (rgb_valid),
	.rgb       (rgb)
);

// File: sprite_rom.hex
// one row word per line, eight rows per sprite, sprites in id order 0 to 3
// eight 4-bit colour indices per word, column 0 leftmost, index 0 is transparent
11111111
10000001
10222201
10200201
10200201
10222201
10000001
11111111
20000002
02000020
00200200
00022000
00022000
00200200
02000020
20000002
30303030
03030303
30303030
03030303
30303030
03030303
30303030
03030303
56789ABC
6789ABCD
789ABCDE
89ABCDEF
0000FFFF
FFFF0000
E0E0E0E0
0D0D0D0D

// File: sprite_rom.sv
// packed sprite ROM
// one sprite row per word, eight 4-bit indices, column 0 in the top nibble
module sprite_rom (
	input  logic                  Clk50,
	input  sprite_pkg::rom_addr_t addr,
	output sprite_pkg::rom_word_t data
);
	import sprite_pkg::*;

	// 4 sprites x 8 rows
	rom_word_t mem [ROM_WORDS];

	// contents fixed at build time
	initial
	begin
		$readmemh("sprite_rom.hex", mem);
	end

	// --------------------------------------------------
	// synchronous read, every cycle
	// --------------------------------------------------
	always_ff @(posedge Clk50)
	begin
		data <= mem[addr];
	end

endmodule

// File: sprite_table.sv
// sprite position table
// per sprite corner and enable, written by a strobe
module sprite_table #(
	parameter int NUM_SPRITES = 4
) (
	input  logic                    Clk50,
	input  logic                    rst_n,
	input  logic                    wr_valid,
	input  sprite_pkg::sprite_wr_t  wr,
	output sprite_pkg::sprite_pos_t pos [NUM_SPRITES]
);
	import sprite_pkg::*;

	// one write select per entry
	logic sel [NUM_SPRITES];

	for (genvar i = 0; i < NUM_SPRITES; i++)
	begin : g_entry
		// ids at or above NUM_SPRITES match no entry
		assign sel[i] = wr_valid && (wr.id == sprite_id_t'(i));

		// enable bit
		always_ff @(posedge Clk50)
		begin
			if (!rst_n)
				pos[i].en <= 1'b0;
			else if (sel[i])
				pos[i].en <= wr.pos.en;
		end

		// corner coordinates
		always_ff @(posedge Clk50)
		begin
			if (sel[i])
			begin
				pos[i].x <= wr.pos.x;
				pos[i].y <= wr.pos.y;
			end
		end
	end

endmodule

// File: tb_sprite_renderer.sv
// sprite renderer testbench
// directed and random pixel requests checked against a reference model
module tb_sprite_renderer;
	timeunit 1ns;
	timeprecision 100ps;
	import sprite_pkg::*;

	localparam int NUM_SPRITES   = 4;
	// requests per test
	localparam int DISABLED_REQS = 16;
	localparam int SWEEP_REQS    = 100;
	localparam int OVERLAP_REQS  = 144;
	localparam int BLANK_REQS    = 32;
	localparam int RANDOM_REQS   = 400;
	localparam int TOTAL_REQS    = DISABLED_REQS + SWEEP_REQS + OVERLAP_REQS
		+ BLANK_REQS + RANDOM_REQS;
	localparam int WATCHDOG_NS   = (TOTAL_REQS + 100) * 8;
	localparam int DRAIN_LIMIT   = 12;

	logic        Clk50;
	logic        rst_n;
	logic        pix_valid;
	pixel_req_t  pix;
	logic        tbl_wr_valid;
	sprite_wr_t  tbl_wr;
	logic        rgb_valid;
	rgb_t        rgb;

	// reference model state
	sprite_pos_t table_model [NUM_SPRITES];
	rom_word_t   rom_model [ROM_WORDS];
	rgb_t        expected_q [$];
	rgb_t        expected_head;
	int unsigned rand_state;
	int          req_count;
	int          out_count;

	sprite_renderer #(.NUM_SPRITES(NUM_SPRITES)) sprite_renderer_inst (
		.Clk50        (Clk50),
		.rst_n        (rst_n),
		.pix_valid    (pix_valid),
		.pix          (pix),
		.tbl_wr_valid (tbl_wr_valid),
		.tbl_wr       (tbl_wr),
		.rgb_valid    (rgb_valid),
		.rgb          (rgb)
	);

	// 8 ns period
	always #4 Clk50 = ~Clk50;

	// --------------------------------------------------
	// failure and compare helpers
	// --------------------------------------------------
	task automatic stop_on_failure(string reason);
		$display("%s", reason);
		$display("TESTBENCH FAILED");
		$fatal(1, "stopped at the first error");
	endtask

	task automatic check_rgb(string name, rgb_t got, rgb_t exp);
		if (got !== exp)
			stop_on_failure($sformatf("error: %s got %h expected %h", name, got, exp));
	endtask

	task automatic check_count(string name, int got, int exp);
		if (got != exp)
			stop_on_failure($sformatf("error: %s got %h expected %h", name, got, exp));
	endtask

	// lcg step with the upper bits returned
	function automatic int unsigned next_random();
		rand_state = rand_state * 32'd1664525 + 32'd1013904223;
		return rand_state >> 8;
	endfunction

	function automatic pixel_req_t make_req(int x, int y, bit blank);
		pixel_req_t req;
		req.x     = coord_t'(x);
		req.y     = coord_t'(y);
		req.blank = blank;
		return req;
	endfunction

	function automatic sprite_wr_t make_wr(int id, int x, int y, bit en);
		sprite_wr_t wr;
		wr.id     = sprite_id_t'(id);
		wr.pos.x  = coord_t'(x);
		wr.pos.y  = coord_t'(y);
		wr.pos.en = en;
		return wr;
	endfunction

	// --------------------------------------------------
	// reference model
	// --------------------------------------------------
	// top-most enabled sprite covering the pixel decides
	// and a transparent pixel of it shows the background
	function automatic rgb_t expected_rgb(pixel_req_t req);
		int         i;
		int         px;
		int         py;
		int         sx;
		int         sy;
		rom_word_t  word;
		color_idx_t idx;
		if (req.blank)
			return rgb_t'(24'h000000);
		px = int'(req.x);
		py = int'(req.y);
		for (i = NUM_SPRITES - 1; i >= 0; i--)
		begin
			sx = int'(table_model[i].x);
			sy = int'(table_model[i].y);
			if (table_model[i].en && px >= sx && px < sx + SPRITE_SIZE
				&& py >= sy && py < sy + SPRITE_SIZE)
			begin
				word = rom_model[i * SPRITE_SIZE + (py - sy)];
				// leftmost pixel in the top nibble
				idx = color_idx_t'((word >> (4 * (SPRITE_SIZE - 1 - (px - sx)))) & 32'hF);
				if (idx == 4'h0)
					idx = BG_INDEX;
				return palette_rgb(idx);
			end
		end
		return palette_rgb(BG_INDEX);
	endfunction

	// one cycle of stimulus 1 ns after the edge
	// expected value taken before the write lands
	task automatic drive_cycle(bit do_req, pixel_req_t req, bit do_wr, sprite_wr_t wr);
		@(posedge Clk50);
		#1;
		pix_valid    = do_req;
		pix          = req;
		tbl_wr_valid = do_wr;
		tbl_wr       = wr;
		if (do_req)
		begin
			expected_q.push_back(expected_rgb(req));
			req_count++;
		end
		if (do_wr && int'(wr.id) < NUM_SPRITES)
			table_model[wr.id] = wr.pos;
	endtask

	// idle inputs and wait for the queue to empty
	task automatic wait_for_drain();
		int waited;
		drive_cycle(1'b0, '0, 1'b0, '0);
		waited = 0;
		while (expected_q.size() != 0 && waited < DRAIN_LIMIT)
		begin
			@(posedge Clk50);
			waited++;
		end
		if (expected_q.size() != 0)
			stop_on_failure("an expected output never arrived");
	endtask

	// outputs sampled on the falling edge
	always @(negedge Clk50)
	begin
		if (rst_n === 1'b1 && rgb_valid === 1'b1)
		begin
			if (expected_q.size() == 0)
				stop_on_failure("an output arrived with no request pending");
			else
			begin
				expected_head = expected_q.pop_front();
				check_rgb("rgb", rgb, expected_head);
				out_count++;
			end
		end
	end

	// --------------------------------------------------
	// tests
	// --------------------------------------------------
	// quiet after reset and all sprites disabled
	task automatic run_disabled();
		int i;
		for (i = 0; i < 10; i++)
			drive_cycle(1'b0, '0, 1'b0, '0);
		// requests around the origin where a zeroed entry would sit
		for (i = 0; i < DISABLED_REQS; i++)
			drive_cycle(1'b1, make_req(int'(next_random() % 12),
				int'(next_random() % 12), 1'b0), 1'b0, '0);
		wait_for_drain();
	endtask

	// sprite 2 alone over its box plus a one pixel border
	task automatic run_single_sweep();
		int x;
		int y;
		drive_cycle(1'b0, '0, 1'b1, make_wr(2, 200, 150, 1'b1));
		for (y = 149; y < 159; y++)
			for (x = 199; x < 209; x++)
				drive_cycle(1'b1, make_req(x, y, 1'b0), 1'b0, '0);
		wait_for_drain();
	endtask

	// three stacked layers with sprite 3 on top
	task automatic run_overlap();
		int x;
		int y;
		drive_cycle(1'b0, '0, 1'b1, make_wr(0, 102, 102, 1'b1));
		drive_cycle(1'b0, '0, 1'b1, make_wr(1, 100, 100, 1'b1));
		drive_cycle(1'b0, '0, 1'b1, make_wr(3, 104, 104, 1'b1));
		for (y = 100; y < 112; y++)
			for (x = 100; x < 112; x++)
				drive_cycle(1'b1, make_req(x, y, 1'b0), 1'b0, '0);
		wait_for_drain();
	endtask

	task automatic run_blank();
		int i;
		for (i = 0; i < BLANK_REQS; i++)
			drive_cycle(1'b1, make_req(96 + int'(next_random() % 32),
				96 + int'(next_random() % 32), 1'b1), 1'b0, '0);
		wait_for_drain();
	endtask

	// back to back requests with writes mixed in
	// every 40th cycle carries a write only
	task automatic run_random_stream();
		int         sent;
		int         cyc;
		bit         do_req;
		bit         do_wr;
		pixel_req_t req;
		sprite_wr_t wr;
		sent = 0;
		cyc  = 0;
		while (sent < RANDOM_REQS)
		begin
			do_wr  = (next_random() % 4) == 0;
			wr     = make_wr(int'(next_random() % 4), 96 + int'(next_random() % 36),
				96 + int'(next_random() % 36), (next_random() % 4) != 0);
			req    = make_req(96 + int'(next_random() % 40), 96 + int'(next_random() % 40),
				(next_random() % 16) == 0);
			do_req = 1'b1;
			if (cyc % 40 == 39)
			begin
				do_req = 1'b0;
				do_wr  = 1'b1;
			end
			drive_cycle(do_req, req, do_wr, wr);
			if (do_req)
				sent++;
			cyc++;
		end
		wait_for_drain();
	endtask

	initial
	begin
		#(WATCHDOG_NS);
		stop_on_failure("watchdog timeout, the run did not finish in time");
	end

	initial
	begin
		int i;
		Clk50        = 1'b0;
		rst_n        = 1'b0;
		pix_valid    = 1'b0;
		pix          = '0;
		tbl_wr_valid = 1'b0;
		tbl_wr       = '0;
		rand_state   = 99284;
		req_count    = 0;
		out_count    = 0;
		for (i = 0; i < NUM_SPRITES; i++)
			table_model[i] = '0;
		$readmemh("sprite_rom.hex", rom_model);
		repeat (8) @(posedge Clk50);
		#1;
		rst_n = 1'b1;
		run_disabled();
		run_single_sweep();
		run_overlap();
		run_blank();
		run_random_stream();
		check_count("output count", out_count, req_count);
		$display("TESTBENCH PASSED");
		$finish;
	end

endmodule
